// File: gol_pkg.sv
// Board geometry, row and request types for the life engine, the arbiter and the board RAM
package gol_pkg;

   // The board is square and wraps around at every edge
   localparam int ROWS = 16;
   localparam int COLS = 16;

   // One row holds one cell per bit, and bit 0 is column 0
   typedef logic [COLS-1:0] row_t;

   // Four index bits cover the board, so the usual modulo arithmetic gives wraparound
   typedef logic [3:0] row_idx_t;
   typedef logic [3:0] col_idx_t;

   // Generations completed in the current run
   typedef logic [15:0] gen_cnt_t;

   // One request to the single port of the board memory
   typedef struct packed {
      logic     en;
      logic     we;
      row_idx_t row;
      row_t     data;
   } mem_req_t;

   // Index of the bottom row, where a read or write sweep ends
   localparam row_idx_t LAST_ROW = row_idx_t'(ROWS - 1);

   // A dead cell is born with exactly three live neighbours
   localparam logic [3:0] BIRTH_NBRS = 4'd3;

   // A live cell also survives with two live neighbours
   localparam logic [3:0] SURVIVE_NBRS = 4'd2;

endpackage

// File: avmm_pkg.sv
// Avalon-MM slave types, the address decode union and the register map of the life persona
package avmm_pkg;

   // Request as the host presents it, held while waitrequest is high
   typedef struct packed {
      logic        read;
      logic        write;
      logic [15:0] address;
      logic [31:0] writedata;
   } avmm_req_t;

   // Response back to the host, with one readdatavalid pulse per accepted read
   typedef struct packed {
      logic        waitrequest;
      logic [31:0] readdata;
      logic        readdatavalid;
   } avmm_rsp_t;

   // Register window, selected when the top address bit is clear
   typedef struct packed {
      logic       win;
      logic [6:0] rsvd;
      logic [7:0] idx;
   } reg_view_t;

   // Row window, selected when the top address bit is set
   typedef struct packed {
      logic        win;
      logic [10:0] rsvd;
      logic [3:0]  row;
   } row_view_t;

   // The same word address, read as either a register selector or a row index
   typedef union packed {
      reg_view_t reg_view;
      row_view_t row_view;
   } avmm_addr_u;

   // Register indices inside the register window
   localparam logic [7:0] REG_CTRL   = 8'd0;
   localparam logic [7:0] REG_STATUS = 8'd1;
   localparam logic [7:0] REG_ID     = 8'd2;

   // Layout of the status word
   typedef struct packed {
      logic        busy;
      logic        running;
      logic [13:0] rsvd;
      logic [15:0] gen_count;
   } status_t;

endpackage

// File: board_ram.sv
// Single-port board memory holding one 16-bit row per word, read data registered
module board_ram
(
   input  logic              pr_region_clk,
   input  gol_pkg::mem_req_t req,
   output gol_pkg::row_t     rdata
);

   import gol_pkg::*;

   // The whole board lives here, one word per row
   row_t mem [ROWS];

   // One port, so a write and its returned read share the same row address
   always_ff @(posedge pr_region_clk)
   begin
      if (req.en)
      begin
         // A write still returns the old row, giving read-before-write behaviour
         if (req.we)
         begin
            mem[req.row] <= req.data;
         end
         rdata <= mem[req.row];
      end
   end

endmodule

// File: board_arbiter.sv
// Fixed-priority arbiter that shares the board RAM port between host accesses and the engine
module board_arbiter
(
   input  logic              pr_region_clk,
   input  logic              rst,
   input  gol_pkg::mem_req_t host_req,
   input  gol_pkg::mem_req_t eng_req,
   output logic              host_gnt,
   output logic              eng_gnt,
   output gol_pkg::mem_req_t ram_req
);

   import gol_pkg::*;

   // The host always wins, so a row access never stalls behind the engine
   assign host_gnt = host_req.en;

   // The engine gets every cycle the host leaves free
   assign eng_gnt = eng_req.en && !host_req.en;

   // Only the winner reaches the RAM
   // Read data is not routed here, since each requester keeps its own registered grant
   always_comb
   begin
      if (host_gnt)
      begin
         ram_req = host_req;
      end
      else if (eng_gnt)
      begin
         ram_req = eng_req;
      end
      else
      begin
         ram_req = '0;
      end
   end

   // At most one requester owns the RAM port in any cycle
   a_gnt_exclusive: assert property (@(posedge pr_region_clk) disable iff (rst)
      !(host_gnt && eng_gnt));

   // A refused engine request stays unchanged until it is granted
   a_eng_req_held: assert property (@(posedge pr_region_clk) disable iff (rst)
      (eng_req.en && !eng_gnt) |=> $stable(eng_req));

endmodule

// File: gol_engine.sv
// Life engine that reads the whole board, applies the life rule with wraparound and writes it back
module gol_engine
(
   input  logic              pr_region_clk,
   input  logic              rst,
   input  logic              run_strobe,
   input  gol_pkg::gen_cnt_t gen_target,
   input  logic              run_enable,
   output gol_pkg::mem_req_t mem_req,
   input  logic              mem_gnt,
   input  gol_pkg::row_t     mem_rdata,
   output logic              busy,
   output gol_pkg::gen_cnt_t gen_count
);

   import gol_pkg::*;

   // Read sweep, one cycle to catch the last row, then the write sweep
   typedef enum logic [1:0] {ENG_IDLE, ENG_READ, ENG_DRAIN, ENG_WRITE} eng_state_t;

   eng_state_t state;
   row_idx_t   idx;
   row_idx_t   up_idx;
   row_idx_t   dn_idx;
   row_idx_t   rd_row_q;
   logic       rd_gnt_q;
   gen_cnt_t   target_q;
   gen_cnt_t   next_count;
   row_t       new_row;

   // Copy of the previous generation, so writes to the RAM cannot disturb neighbours
   row_t board [ROWS];

   // Next state of one row from the rows above, at and below it
   function automatic row_t life_row(row_t up, row_t mid, row_t dn);
      row_t     nxt;
      col_idx_t cc;
      col_idx_t cl;
      col_idx_t cr;
      logic [3:0] n;
      for (int c = 0; c < COLS; c++)
      begin
         cc = col_idx_t'(c);
         // Four-bit columns wrap from 0 to 15 and back on their own
         cl = cc - 1'b1;
         cr = cc + 1'b1;
         n = 4'(up[cl]) + 4'(up[cc]) + 4'(up[cr]) + 4'(mid[cl]) + 4'(mid[cr])
             + 4'(dn[cl]) + 4'(dn[cc]) + 4'(dn[cr]);
         nxt[c] = (n == BIRTH_NBRS) || (mid[cc] && (n == SURVIVE_NBRS));
      end
      return nxt;
   endfunction

   // Neighbour rows of the row being written, wrapping top to bottom
   assign up_idx = idx - 1'b1;
   assign dn_idx = idx + 1'b1;

   assign new_row    = life_row(board[up_idx], board[idx], board[dn_idx]);
   assign next_count = gen_count + 1'b1;
   assign busy       = (state != ENG_IDLE);

   // The request stays up, unchanged, until the arbiter grants it
   always_comb
   begin
      mem_req      = '0;
      mem_req.en   = (state == ENG_READ) || (state == ENG_WRITE);
      mem_req.we   = (state == ENG_WRITE);
      mem_req.row  = idx;
      // Reads carry no data, so the buffer may fill while a read request waits
      if (state == ENG_WRITE)
      begin
         mem_req.data = new_row;
      end
   end

   always_ff @(posedge pr_region_clk)
   begin
      if (rst)
      begin
         state     <= ENG_IDLE;
         idx       <= '0;
         gen_count <= '0;
         rd_gnt_q  <= 1'b0;
      end
      else
      begin
         // Marks which cycles of the shared read bus carry engine data
         rd_gnt_q <= (state == ENG_READ) && mem_gnt;
         case (state)
            ENG_IDLE:
            begin
               // A zero target clears the count and leaves the engine idle
               if (run_strobe && run_enable)
               begin
                  gen_count <= '0;
                  idx       <= '0;
                  if (gen_target != '0)
                  begin
                     state <= ENG_READ;
                  end
               end
            end
            ENG_READ:
            begin
               if (mem_gnt)
               begin
                  idx <= idx + 1'b1;
                  if (idx == LAST_ROW)
                  begin
                     state <= ENG_DRAIN;
                  end
               end
            end
            ENG_DRAIN:
            begin
               // The bottom row lands in the buffer at the end of this cycle
               state <= ENG_WRITE;
            end
            ENG_WRITE:
            begin
               if (mem_gnt)
               begin
                  idx <= idx + 1'b1;
                  if (idx == LAST_ROW)
                  begin
                     gen_count <= next_count;
                     // Stop requests are honoured only between generations
                     if ((next_count == target_q) || !run_enable)
                     begin
                        state <= ENG_IDLE;
                     end
                     else
                     begin
                        state <= ENG_READ;
                     end
                  end
               end
            end
            default:
            begin
               state <= ENG_IDLE;
            end
         endcase
      end
   end

   // Run target, read row tag and the board buffer
   always_ff @(posedge pr_region_clk)
   begin
      if ((state == ENG_IDLE) && run_strobe)
      begin
         target_q <= gen_target;
      end
      rd_row_q <= idx;
      // RAM data arrives one cycle after the grant, tagged with the row then requested
      if (rd_gnt_q)
      begin
         board[rd_row_q] <= mem_rdata;
      end
   end

endmodule

// File: avmm_csr.sv
// Avalon-MM slave serving the control registers and mapping the row window onto board accesses
module avmm_csr
#(
   parameter logic [31:0] PERSONA_ID = 32'h0000_6011
)
(
   input  logic                pr_region_clk,
   input  logic                rst,
   input  avmm_pkg::avmm_req_t bus_req,
   output avmm_pkg::avmm_rsp_t bus_rsp,
   output gol_pkg::mem_req_t   mem_req,
   input  logic                mem_gnt,
   input  gol_pkg::row_t       mem_rdata,
   output logic                run_strobe,
   output gol_pkg::gen_cnt_t   gen_target,
   input  logic                busy,
   input  logic                running,
   input  gol_pkg::gen_cnt_t   gen_count
);

   import avmm_pkg::*;
   import gol_pkg::*;

   avmm_addr_u  addr;
   logic        row_acc;
   logic        reg_rd;
   logic        row_pend_q;
   logic        rdv_q;
   logic [31:0] rdata_q;
   logic [31:0] reg_rdata;
   status_t     status;

   assign addr = bus_req.address;

   // Any access with the top address bit set goes to the board
   assign row_acc = (bus_req.read || bus_req.write) && addr.row_view.win;

   // Register reads never stall
   assign reg_rd = bus_req.read && !addr.reg_view.win;

   // Row accesses become host requests to the arbiter, presented in the same cycle
   always_comb
   begin
      mem_req      = '0;
      mem_req.en   = row_acc;
      mem_req.we   = bus_req.write;
      mem_req.row  = addr.row_view.row;
      mem_req.data = row_t'(bus_req.writedata[COLS-1:0]);
   end

   // A run starts only on a CTRL write while the region runs and the engine is idle
   assign run_strobe = bus_req.write && !addr.reg_view.win && (addr.reg_view.idx == REG_CTRL)
                       && running && !busy;
   assign gen_target = gen_cnt_t'(bus_req.writedata[15:0]);

   // Status word for the host
   always_comb
   begin
      status           = '0;
      status.busy      = busy;
      status.running   = running;
      status.gen_count = gen_count;
   end

   // Register read mux, unmapped indices and CTRL read as zero
   always_comb
   begin
      case (addr.reg_view.idx)
         REG_STATUS: reg_rdata = status;
         REG_ID:     reg_rdata = PERSONA_ID;
         default:    reg_rdata = '0;
      endcase
   end

   always_ff @(posedge pr_region_clk)
   begin
      if (rst)
      begin
         row_pend_q <= 1'b0;
         rdv_q      <= 1'b0;
      end
      else
      begin
         // The host's own registered grant picks its data off the shared RAM bus
         row_pend_q <= bus_req.read && addr.row_view.win && mem_gnt;
         rdv_q      <= reg_rd || row_pend_q;
      end
   end

   // Read data register, loaded from the register mux or from the RAM one cycle later
   always_ff @(posedge pr_region_clk)
   begin
      if (reg_rd)
      begin
         rdata_q <= reg_rdata;
      end
      else if (row_pend_q)
      begin
         rdata_q <= {16'b0, mem_rdata};
      end
   end

   // Row accesses stall until the arbiter lets them through
   assign bus_rsp.waitrequest   = row_acc && !mem_gnt;
   assign bus_rsp.readdata      = rdata_q;
   assign bus_rsp.readdatavalid = rdv_q;

   // The host never asks for a read and a write together
   a_no_rd_wr: assert property (@(posedge pr_region_clk) disable iff (rst)
      !(bus_req.read && bus_req.write));

endmodule

// File: pr_handshake_ctrl.sv
// PR start and stop handshake sequencer that drives freeze and the engine run enable
module pr_handshake_ctrl
(
   input  logic pr_region_clk,
   input  logic rst,
   input  logic start_req,
   output logic start_ack,
   input  logic stop_req,
   output logic stop_ack,
   output logic freeze,
   output logic run_enable,
   input  logic busy
);

   typedef enum logic [1:0] {PR_IDLE, PR_RUNNING, PR_STOPPED} pr_state_t;

   pr_state_t state;
   logic      start_rise;

   // The ack is a delayed copy of the request, so it also marks the request's last value
   assign start_rise = start_req && !start_ack;

   always_ff @(posedge pr_region_clk)
   begin
      if (rst)
      begin
         state     <= PR_IDLE;
         start_ack <= 1'b0;
      end
      else
      begin
         start_ack <= start_req;
         case (state)
            PR_IDLE,
            PR_RUNNING:
            begin
               // Stop waits for the engine to finish its run
               if (stop_req && !busy)
               begin
                  state <= PR_STOPPED;
               end
               else if (start_rise)
               begin
                  state <= PR_RUNNING;
               end
            end
            PR_STOPPED:
            begin
               // Only a fresh start request lifts freeze
               if (start_rise)
               begin
                  state <= PR_RUNNING;
               end
            end
            default:
            begin
               state <= PR_IDLE;
            end
         endcase
      end
   end

   // The stop ack follows its request while the region is parked
   assign stop_ack   = (state == PR_STOPPED) && stop_req;
   assign freeze     = (state == PR_STOPPED);
   assign run_enable = (state == PR_RUNNING);

   // The engine is always idle when the stop is acknowledged
   a_stop_ack_idle: assert property (@(posedge pr_region_clk) disable iff (rst)
      $rose(stop_ack) |-> !busy);

endmodule

// File: gol_persona_top.sv
// Top of the life persona that the PR wrapper instantiates, wiring the slave, handshake and engine
module gol_persona_top
#(
   parameter logic [31:0] PERSONA_ID = 32'h0000_6011
)
(
   input  logic                pr_region_clk,
   input  logic                rst,
   input  avmm_pkg::avmm_req_t bus_req,
   output avmm_pkg::avmm_rsp_t bus_rsp,
   input  logic                start_req,
   output logic                start_ack,
   input  logic                stop_req,
   output logic                stop_ack,
   output logic                freeze
);

   import gol_pkg::*;

   // Board port traffic on each side of the arbiter
   mem_req_t host_req;
   mem_req_t eng_req;
   mem_req_t ram_req;
   logic     host_gnt;
   logic     eng_gnt;
   row_t     ram_rdata;

   // Run control between the slave, the engine and the handshake
   logic     run_strobe;
   gen_cnt_t gen_target;
   gen_cnt_t gen_count;
   logic     busy;
   logic     run_enable;

   avmm_csr #(
      .PERSONA_ID (PERSONA_ID)
   ) u_csr (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .bus_req       (bus_req),
      .bus_rsp       (bus_rsp),
      .mem_req       (host_req),
      .mem_gnt       (host_gnt),
      .mem_rdata     (ram_rdata),
      .run_strobe    (run_strobe),
      .gen_target    (gen_target),
      .busy          (busy),
      .running       (run_enable),
      .gen_count     (gen_count)
   );

   pr_handshake_ctrl u_handshake (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .start_req     (start_req),
      .start_ack     (start_ack),
      .stop_req      (stop_req),
      .stop_ack      (stop_ack),
      .freeze        (freeze),
      .run_enable    (run_enable),
      .busy          (busy)
   );

   gol_engine u_engine (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .run_strobe    (run_strobe),
      .gen_target    (gen_target),
      .run_enable    (run_enable),
      .mem_req       (eng_req),
      .mem_gnt       (eng_gnt),
      .mem_rdata     (ram_rdata),
      .busy          (busy),
      .gen_count     (gen_count)
   );

   // Both requesters watch the same RAM read bus
   board_arbiter u_arbiter (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .host_req      (host_req),
      .eng_req       (eng_req),
      .host_gnt      (host_gnt),
      .eng_gnt       (eng_gnt),
      .ram_req       (ram_req)
   );

   board_ram u_ram (
      .pr_region_clk (pr_region_clk),
      .req           (ram_req),
      .rdata         (ram_rdata)
   );

endmodule

// File: tb_gol_persona.sv
// Directed testbench for the life persona, driving the Avalon-MM port and the PR handshake pins
module tb_gol_persona;

   timeunit 1ns;
   timeprecision 1ps;

   import avmm_pkg::*;
   import gol_pkg::*;

   localparam logic [31:0] ID_VALUE    = 32'h5A5A_6011;
   localparam logic [15:0] ROW_BASE    = 16'h8000;
   localparam logic [15:0] CTRL_ADDR   = {8'h00, REG_CTRL};
   localparam logic [15:0] STATUS_ADDR = {8'h00, REG_STATUS};
   localparam logic [15:0] ID_ADDR     = {8'h00, REG_ID};
   localparam int          CYCLE_LIMIT = 64;
   localparam int          POLL_LIMIT  = 400;

   logic      pr_region_clk;
   logic      rst;
   avmm_req_t bus_req;
   avmm_rsp_t bus_rsp;
   logic      start_req;
   logic      start_ack;
   logic      stop_req;
   logic      stop_ack;
   logic      freeze;

   string     test_name;
   int        error_count;

   // Expected board contents, kept in step with every run the DUT makes
   row_t      model [ROWS];

   gol_persona_top #(
      .PERSONA_ID (ID_VALUE)
   ) gol_persona_top_i (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .bus_req       (bus_req),
      .bus_rsp       (bus_rsp),
      .start_req     (start_req),
      .start_ack     (start_ack),
      .stop_req      (stop_req),
      .stop_ack      (stop_ack),
      .freeze        (freeze)
   );

   // Free-running 8 ns clock
   always #4 pr_region_clk = ~pr_region_clk;

   task automatic fail_timeout(input string what);
      $display("TIMEOUT in test %s: %s", test_name, what);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped after a timeout");
   endtask

   task automatic check_eq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("CHECK FAILED test=%s check=%s expected=%h actual=%h",
                  test_name, what, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "Simulation stopped at the first mismatch");
      end
   endtask

   // Present a write, hold it through waitrequest, then drop it after the accepting edge
   task automatic avmm_write(input logic [15:0] addr, input logic [31:0] data);
      avmm_req_t req;
      int        cycles;
      req           = '0;
      req.write     = 1'b1;
      req.address   = addr;
      req.writedata = data;
      cycles        = 0;
      @(posedge pr_region_clk);
      bus_req <= req;
      @(negedge pr_region_clk);
      while (bus_rsp.waitrequest)
      begin
         cycles++;
         if (cycles > CYCLE_LIMIT)
         begin
            fail_timeout("waitrequest stayed high on a write");
         end
         @(negedge pr_region_clk);
      end
      // The next rising edge takes the request
      @(posedge pr_region_clk);
      bus_req <= '0;
   endtask

   // Same acceptance as a write, followed by the wait for the single readdatavalid pulse
   task automatic avmm_read(input logic [15:0] addr, output logic [31:0] data);
      avmm_req_t req;
      int        cycles;
      req         = '0;
      req.read    = 1'b1;
      req.address = addr;
      cycles      = 0;
      @(posedge pr_region_clk);
      bus_req <= req;
      @(negedge pr_region_clk);
      while (bus_rsp.waitrequest)
      begin
         cycles++;
         if (cycles > CYCLE_LIMIT)
         begin
            fail_timeout("waitrequest stayed high on a read");
         end
         @(negedge pr_region_clk);
      end
      @(posedge pr_region_clk);
      bus_req <= '0;
      cycles = 0;
      @(negedge pr_region_clk);
      while (!bus_rsp.readdatavalid)
      begin
         cycles++;
         if (cycles > CYCLE_LIMIT)
         begin
            fail_timeout("readdatavalid never came back for a read");
         end
         @(negedge pr_region_clk);
      end
      data = bus_rsp.readdata;
   endtask

   task automatic wait_start_ack(input logic level);
      int cycles;
      cycles = 0;
      @(negedge pr_region_clk);
      while (start_ack !== level)
      begin
         cycles++;
         if (cycles > CYCLE_LIMIT)
         begin
            fail_timeout("start_ack did not follow start_req");
         end
         @(negedge pr_region_clk);
      end
   endtask

   task automatic wait_stop_ack(input logic level);
      int cycles;
      cycles = 0;
      @(negedge pr_region_clk);
      while (stop_ack !== level)
      begin
         cycles++;
         if (cycles > CYCLE_LIMIT)
         begin
            fail_timeout("stop_ack did not follow stop_req");
         end
         @(negedge pr_region_clk);
      end
   endtask

   // Poll the status register until the engine reports idle
   task automatic wait_idle(output logic [31:0] status);
      int polls;
      polls = 0;
      avmm_read(STATUS_ADDR, status);
      while (status[31])
      begin
         polls++;
         if (polls > POLL_LIMIT)
         begin
            fail_timeout("busy never cleared after a run");
         end
         avmm_read(STATUS_ADDR, status);
      end
   endtask

   // One generation of the life rule on the model, wrapping at every edge
   task automatic life_model_step();
      row_t nxt [ROWS];
      int   n;
      int   rr;
      int   cc;
      for (int r = 0; r < ROWS; r++)
      begin
         for (int c = 0; c < COLS; c++)
         begin
            n = 0;
            for (int dr = -1; dr <= 1; dr++)
            begin
               for (int dc = -1; dc <= 1; dc++)
               begin
                  rr = (r + dr + ROWS) % ROWS;
                  cc = (c + dc + COLS) % COLS;
                  if ((dr != 0 || dc != 0) && model[rr][cc])
                  begin
                     n++;
                  end
               end
            end
            // Birth on three, survival on two or three
            nxt[r][c] = (n == 3) || (model[r][c] && (n == 2));
         end
      end
      for (int r = 0; r < ROWS; r++)
      begin
         model[r] = nxt[r];
      end
   endtask

   task automatic load_board();
      for (int r = 0; r < ROWS; r++)
      begin
         avmm_write(ROW_BASE | 16'(r), {16'h0000, model[r]});
      end
   endtask

   task automatic check_board();
      logic [31:0] d;
      for (int r = 0; r < ROWS; r++)
      begin
         avmm_read(ROW_BASE | 16'(r), d);
         check_eq($sformatf("row %0d", r), {16'h0000, model[r]}, d);
      end
   endtask

   // Start a run, wait for it to end and advance the model by the same count
   task automatic run_and_check(input logic [15:0] target);
      logic [31:0] st;
      avmm_write(CTRL_ADDR, {16'h0000, target});
      wait_idle(st);
      check_eq("status after run", {16'h4000, target}, st);
      for (int g = 0; g < target; g++)
      begin
         life_model_step();
      end
      check_board();
   endtask

   task automatic test_reset();
      logic [31:0] d;
      test_name = "reset";
      @(negedge pr_region_clk);
      check_eq("start_ack", 32'h0, start_ack);
      check_eq("stop_ack", 32'h0, stop_ack);
      check_eq("freeze", 32'h0, freeze);
      avmm_read(STATUS_ADDR, d);
      check_eq("status", 32'h0, d);
      avmm_read(ID_ADDR, d);
      check_eq("identity", ID_VALUE, d);
   endtask

   task automatic test_row_window();
      test_name = "row_window";
      for (int r = 0; r < ROWS; r++)
      begin
         model[r] = row_t'($urandom);
      end
      load_board();
      check_board();
   endtask

   task automatic test_start();
      logic [31:0] d;
      test_name = "start";
      // The region is not running yet, so this write has no effect
      avmm_write(CTRL_ADDR, 32'd5);
      avmm_read(STATUS_ADDR, d);
      check_eq("status before start", 32'h0, d);
      @(posedge pr_region_clk);
      start_req <= 1'b1;
      wait_start_ack(1'b1);
      check_eq("freeze after start", 32'h0, freeze);
      avmm_read(STATUS_ADDR, d);
      check_eq("status after start", 32'h4000_0000, d);
      @(posedge pr_region_clk);
      start_req <= 1'b0;
      wait_start_ack(1'b0);
   endtask

   task automatic test_blinker();
      test_name = "blinker";
      for (int r = 0; r < ROWS; r++)
      begin
         model[r] = '0;
      end
      // Vertical bar of three cells in column 5
      model[4] = 16'h0020;
      model[5] = 16'h0020;
      model[6] = 16'h0020;
      load_board();
      run_and_check(16'd1);
      run_and_check(16'd2);
   endtask

   task automatic test_random_run();
      logic [31:0] d;
      logic [31:0] st;
      test_name = "random_run";
      for (int r = 0; r < ROWS; r++)
      begin
         model[r] = row_t'($urandom);
      end
      load_board();
      avmm_write(CTRL_ADDR, 32'd7);
      avmm_read(STATUS_ADDR, d);
      check_eq("busy during run", 32'h1, d[31]);
      // The engine reads all rows before it writes any, so row 3 still holds its loaded value
      avmm_read(ROW_BASE | 16'd3, d);
      check_eq("row read during run", {16'h0000, model[3]}, d);
      wait_idle(st);
      check_eq("status after run", 32'h4000_0007, st);
      for (int g = 0; g < 7; g++)
      begin
         life_model_step();
      end
      check_board();
   endtask

   task automatic test_stop();
      logic [31:0] st;
      int          polls;
      test_name = "stop";
      avmm_write(CTRL_ADDR, 32'd3);
      @(posedge pr_region_clk);
      stop_req <= 1'b1;
      polls = 0;
      avmm_read(STATUS_ADDR, st);
      while (st[31])
      begin
         // The stop must wait for the run to finish
         check_eq("stop_ack while busy", 32'h0, stop_ack);
         check_eq("freeze while busy", 32'h0, freeze);
         polls++;
         if (polls > POLL_LIMIT)
         begin
            fail_timeout("busy never cleared with a stop pending");
         end
         avmm_read(STATUS_ADDR, st);
      end
      wait_stop_ack(1'b1);
      check_eq("freeze after stop", 32'h1, freeze);
      check_eq("generation count", 32'd3, st[15:0]);
      for (int g = 0; g < 3; g++)
      begin
         life_model_step();
      end
      check_board();
      // A run request while frozen is dropped
      avmm_write(CTRL_ADDR, 32'd2);
      avmm_read(STATUS_ADDR, st);
      check_eq("status while stopped", 32'h0000_0003, st);
      @(posedge pr_region_clk);
      stop_req <= 1'b0;
      wait_stop_ack(1'b0);
      check_eq("freeze held", 32'h1, freeze);
      @(posedge pr_region_clk);
      start_req <= 1'b1;
      wait_start_ack(1'b1);
      check_eq("freeze after restart", 32'h0, freeze);
      avmm_read(STATUS_ADDR, st);
      check_eq("status after restart", 32'h4000_0003, st);
      @(posedge pr_region_clk);
      start_req <= 1'b0;
      wait_start_ack(1'b0);
   endtask

   initial
   begin
      int unsigned seed_draw;
      error_count   = 0;
      test_name     = "init";
      pr_region_clk = 1'b0;
      rst           = 1'b1;
      bus_req       = '0;
      start_req     = 1'b0;
      stop_req      = 1'b0;
      seed_draw     = $urandom(40);
      repeat (3) @(posedge pr_region_clk);
      rst <= 1'b0;
      test_reset();
      test_row_window();
      test_start();
      test_blinker();
      test_random_run();
      test_stop();
      if (error_count == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
gol_pkg.sv
avmm_pkg.sv
board_ram.sv
board_arbiter.sv
gol_engine.sv
avmm_csr.sv
pr_handshake_ctrl.sv
gol_persona_top.sv
tb_gol_persona.sv
